//--- logic/mcu_cmd_defines.svh
`ifndef MCU_CMD_DEFINES_SVH
`define MCU_CMD_DEFINES_SVH

// host link widths
`define MCU_ADDR_W   24
`define SPI_CNT_W    8

// uPD77C25 memories
`define DSPX_PGM_AW  11
`define DSPX_DAT_AW  10
`define DSPX_PGM_DW  24
`define DSPX_DAT_DW  16

// power-up mapper
`define MAPPER_RST   3'd1

// answered to command F0
`define READBACK_SIG 8'hA5

`endif

//--- logic/mcu_cmd_pkg.sv
`include "mcu_cmd_defines.svh"

package mcu_cmd_pkg;

  typedef logic [7:0]                  byte_t;
  typedef logic [`SPI_CNT_W-1:0]       spi_cnt_t;
  typedef logic [`MCU_ADDR_W-1:0]      mem_addr_t;
  typedef logic [2:0]                  mapper_t;

  typedef logic [`DSPX_PGM_AW-1:0]     pgm_addr_t;
  typedef logic [`DSPX_DAT_AW-1:0]     dat_addr_t;
  typedef logic [`DSPX_PGM_DW-1:0]     pgm_word_t;
  typedef logic [`DSPX_DAT_DW-1:0]     dat_word_t;

  // upper nibble of the command byte
  typedef enum logic [3:0] {
    GRP_SET_ADDR  = 4'h0,
    GRP_ROM_MASK  = 4'h1,
    GRP_SRAM_MASK = 4'h2,
    GRP_MAPPER    = 4'h3,
    GRP_MEM_READ  = 4'h8,
    GRP_MEM_WRITE = 4'h9,
    GRP_EXT       = 4'hE,
    GRP_SYS       = 4'hF
  } cmd_group_e;

endpackage

//--- logic/mcu_cmd_if.sv
`timescale 1ns/100ps

// byte stream from the MCU link, fanned out to the decode units
interface mcu_cmd_if
  import mcu_cmd_pkg::*;
();

  logic     cmd_ready;
  logic     param_ready;
  byte_t    cmd_data;
  byte_t    param_data;
  spi_cnt_t spi_byte_cnt;

  modport src (
    output cmd_ready,
    output param_ready,
    output cmd_data,
    output param_data,
    output spi_byte_cnt
  );

  modport unit (
    input cmd_ready,
    input param_ready,
    input cmd_data,
    input param_data,
    input spi_byte_cnt
  );

endinterface

//--- logic/mcu_cfg_decode.sv
`timescale 1ns/100ps
`include "mcu_cmd_defines.svh"

module mcu_cfg_decode
  import mcu_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  mcu_cmd_if.unit    host,
  output mapper_t    mcu_mapper,
  output mem_addr_t  rom_mask,
  output mem_addr_t  saveram_mask
);

  cmd_group_e grp;

  assign grp = cmd_group_e'(host.cmd_data[7:4]);

  // masks arrive msb first on bytes 2..4
  function automatic mem_addr_t mask_fill(
    input mem_addr_t cur,
    input spi_cnt_t  idx,
    input byte_t     b
  );
    mem_addr_t nxt;
    nxt = cur;
    case (idx)
      spi_cnt_t'(2): nxt[23:16] = b;
      spi_cnt_t'(3): nxt[15:8]  = b;
      spi_cnt_t'(4): nxt[7:0]   = b;
      default:       nxt        = cur;
    endcase
    return nxt;
  endfunction

  ////////////////////////////////////////
  // mapper and address masks
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mcu_mapper   <= `MAPPER_RST;
      rom_mask     <= '0;
      saveram_mask <= '0;
    end else if (host.cmd_ready) begin
      if (grp == GRP_MAPPER) begin
        mcu_mapper <= host.cmd_data[2:0];
      end
    end else if (host.param_ready) begin
      case (grp)
        GRP_ROM_MASK:
          rom_mask <= mask_fill(rom_mask, host.spi_byte_cnt, host.param_data);
        GRP_SRAM_MASK:
          saveram_mask <= mask_fill(saveram_mask, host.spi_byte_cnt, host.param_data);
        default: begin
          rom_mask     <= rom_mask;
          saveram_mask <= saveram_mask;
        end
      endcase
    end
  end

endmodule

//--- logic/mcu_mem_port.sv
`timescale 1ns/100ps

module mcu_mem_port
  import mcu_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  mcu_cmd_if.unit    host,
  input  byte_t      mem_rdata,
  input  logic       mem_rdy,
  output mem_addr_t  mem_addr,
  output byte_t      mem_wdata,
  output logic       mem_rrq,
  output logic       mem_wrq,
  output logic       rd_done,
  output byte_t      rd_data
);

  cmd_group_e grp;
  logic       strobe;
  logic       is_mem_grp;
  logic [1:0] rdy_sr;
  logic       next_addr;
  byte_t      rdata_q;

  assign grp        = cmd_group_e'(host.cmd_data[7:4]);
  assign strobe     = host.cmd_ready | host.param_ready;
  assign is_mem_grp = (grp == GRP_MEM_READ) || (grp == GRP_MEM_WRITE);

  ////////////////////////////////////////
  // ready edge detection
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdy_sr <= 2'b00;
    end else begin
      rdy_sr <= {rdy_sr[0], mem_rdy};
    end
  end

  assign next_addr = rdy_sr[0] & ~rdy_sr[1];

  // sampled alongside the first ready stage
  always_ff @(posedge clk) begin
    rdata_q <= mem_rdata;
  end

  assign rd_done = next_addr && (grp == GRP_MEM_READ);
  assign rd_data = rdata_q;

  ////////////////////////////////////////
  // request pulses
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_rrq <= 1'b0;
      mem_wrq <= 1'b0;
    end else begin
      mem_rrq <= strobe && (grp == GRP_MEM_READ);
      mem_wrq <= host.param_ready && (grp == GRP_MEM_WRITE);
    end
  end

  always_ff @(posedge clk) begin
    if (host.param_ready && grp == GRP_MEM_WRITE) begin
      mem_wdata <= host.param_data;
    end
  end

  ////////////////////////////////////////
  // memory pointer
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_addr <= '0;
    end else if (host.param_ready && grp == GRP_SET_ADDR) begin
      case (host.spi_byte_cnt)
        spi_cnt_t'(2): mem_addr <= {host.param_data, 16'h0000};
        spi_cnt_t'(3): mem_addr[15:8] <= host.param_data;
        spi_cnt_t'(4): mem_addr[7:0] <= host.param_data;
        default:       mem_addr <= mem_addr;
      endcase
    end else if (next_addr && is_mem_grp && host.cmd_data[3]) begin
      // auto-increment
      mem_addr <= mem_addr + 1'b1;
    end
  end

endmodule

//--- logic/dspx_loader.sv
`timescale 1ns/100ps

module dspx_loader
  import mcu_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  mcu_cmd_if.unit    host,
  output pgm_word_t  dspx_pgm_data,
  output pgm_addr_t  dspx_pgm_addr,
  output logic       dspx_pgm_we,
  output dat_word_t  dspx_dat_data,
  output dat_addr_t  dspx_dat_addr,
  output logic       dspx_dat_we,
  output logic       dspx_reset
);

  logic     ext_param;
  spi_cnt_t idx;

  assign ext_param = host.param_ready && (cmd_group_e'(host.cmd_data[7:4]) == GRP_EXT);
  assign idx       = host.spi_byte_cnt;

  // word assembly, msb first
  always_ff @(posedge clk) begin
    if (ext_param) begin
      if (host.cmd_data[3:0] == 4'h9) begin
        case (idx)
          spi_cnt_t'(2): dspx_pgm_data[23:16] <= host.param_data;
          spi_cnt_t'(3): dspx_pgm_data[15:8]  <= host.param_data;
          spi_cnt_t'(4): dspx_pgm_data[7:0]   <= host.param_data;
          default:       dspx_pgm_data        <= dspx_pgm_data;
        endcase
      end else if (host.cmd_data[3:0] == 4'hA) begin
        case (idx)
          spi_cnt_t'(2): dspx_dat_data[15:8] <= host.param_data;
          spi_cnt_t'(3): dspx_dat_data[7:0]  <= host.param_data;
          default:       dspx_dat_data       <= dspx_dat_data;
        endcase
      end
    end
  end

  ////////////////////////////////////////
  // write strobes, address counters, reset
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dspx_pgm_addr <= '0;
      dspx_dat_addr <= '0;
      dspx_pgm_we   <= 1'b0;
      dspx_dat_we   <= 1'b0;
      dspx_reset    <= 1'b1;
    end else if (ext_param) begin
      case (host.cmd_data[3:0])
        4'h8: begin
          if (idx == spi_cnt_t'(2)) begin
            dspx_pgm_addr <= '0;
            dspx_dat_addr <= '0;
          end
        end
        4'h9: begin
          if (idx == spi_cnt_t'(5)) begin
            dspx_pgm_we <= 1'b1;
          end else if (idx == spi_cnt_t'(6)) begin
            dspx_pgm_we   <= 1'b0;
            dspx_pgm_addr <= dspx_pgm_addr + 1'b1;
          end
        end
        4'hA: begin
          if (idx == spi_cnt_t'(4)) begin
            dspx_dat_we <= 1'b1;
          end else if (idx == spi_cnt_t'(5)) begin
            dspx_dat_we   <= 1'b0;
            dspx_dat_addr <= dspx_dat_addr + 1'b1;
          end
        end
        4'hB: dspx_reset <= host.param_data[0];
        default: dspx_reset <= dspx_reset;
      endcase
    end
  end

endmodule

//--- logic/mcu_readback.sv
`timescale 1ns/100ps
`include "mcu_cmd_defines.svh"

module mcu_readback
  import mcu_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  mcu_cmd_if.unit    host,
  input  logic       rd_done,
  input  byte_t      rd_data,
  output byte_t      spi_data_out
);

  logic strobe;
  logic sys_cmd;

  assign strobe  = host.cmd_ready | host.param_ready;
  assign sys_cmd = cmd_group_e'(host.cmd_data[7:4]) == GRP_SYS;

  ////////////////////////////////////////
  // byte shifted back to the host
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      spi_data_out <= '0;
    end else if (rd_done) begin
      // memory read completes first
      spi_data_out <= rd_data;
    end else if (strobe && sys_cmd) begin
      case (host.cmd_data[3:0])
        4'h0:    spi_data_out <= `READBACK_SIG;
        // echo, also on the command strobe
        4'hF:    spi_data_out <= host.param_data;
        default: spi_data_out <= spi_data_out;
      endcase
    end
  end

endmodule

//--- logic/mcu_cmd_top.sv
`timescale 1ns/100ps

module mcu_cmd_top
  import mcu_cmd_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      cmd_ready,
  input  logic      param_ready,
  input  byte_t     cmd_data,
  input  byte_t     param_data,
  input  spi_cnt_t  spi_byte_cnt,
  input  byte_t     mem_rdata,
  input  logic      mem_rdy,
  output byte_t     spi_data_out,
  output mapper_t   mcu_mapper,
  output mem_addr_t rom_mask,
  output mem_addr_t saveram_mask,
  output mem_addr_t mem_addr,
  output byte_t     mem_wdata,
  output logic      mem_rrq,
  output logic      mem_wrq,
  output pgm_word_t dspx_pgm_data,
  output pgm_addr_t dspx_pgm_addr,
  output logic      dspx_pgm_we,
  output dat_word_t dspx_dat_data,
  output dat_addr_t dspx_dat_addr,
  output logic      dspx_dat_we,
  output logic      dspx_reset
);

  logic  rd_done;
  byte_t rd_data;

  mcu_cmd_if host ();

  assign host.cmd_ready    = cmd_ready;
  assign host.param_ready  = param_ready;
  assign host.cmd_data     = cmd_data;
  assign host.param_data   = param_data;
  assign host.spi_byte_cnt = spi_byte_cnt;

  mcu_cfg_decode u_cfg (
    .clk          (clk),
    .rst_n        (rst_n),
    .host         (host.unit),
    .mcu_mapper   (mcu_mapper),
    .rom_mask     (rom_mask),
    .saveram_mask (saveram_mask)
  );

  mcu_mem_port u_mem (
    .clk       (clk),
    .rst_n     (rst_n),
    .host      (host.unit),
    .mem_rdata (mem_rdata),
    .mem_rdy   (mem_rdy),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rrq   (mem_rrq),
    .mem_wrq   (mem_wrq),
    .rd_done   (rd_done),
    .rd_data   (rd_data)
  );

  dspx_loader u_dspx (
    .clk           (clk),
    .rst_n         (rst_n),
    .host          (host.unit),
    .dspx_pgm_data (dspx_pgm_data),
    .dspx_pgm_addr (dspx_pgm_addr),
    .dspx_pgm_we   (dspx_pgm_we),
    .dspx_dat_data (dspx_dat_data),
    .dspx_dat_addr (dspx_dat_addr),
    .dspx_dat_we   (dspx_dat_we),
    .dspx_reset    (dspx_reset)
  );

  mcu_readback u_rdbk (
    .clk          (clk),
    .rst_n        (rst_n),
    .host         (host.unit),
    .rd_done      (rd_done),
    .rd_data      (rd_data),
    .spi_data_out (spi_data_out)
  );

endmodule

//--- sim/mcu_cmd_props.sv
`timescale 1ns/100ps

module mcu_cmd_props
  import mcu_cmd_pkg::*;
(
  input logic  clk,
  input logic  rst_n,
  input logic  mem_rrq,
  input logic  mem_wrq,
  input logic  mem_rdy,
  input logic  dspx_pgm_we,
  input byte_t cmd_data
);

  logic req;
  logic pending;

  assign req = mem_rrq | mem_wrq;

  // request issued, memory not yet ready
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending <= 1'b0;
    end else if (req) begin
      pending <= 1'b1;
    end else if (mem_rdy) begin
      pending <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // memory handshake
  ////////////////////////////////////////
  a_no_rw_overlap: assert property (@(posedge clk) disable iff (!rst_n)
    !(mem_rrq && mem_wrq))
    else $error("read and write request high together");

  a_rrq_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    mem_rrq |=> !mem_rrq)
    else $error("mem_rrq longer than one cycle");

  a_wrq_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    mem_wrq |=> !mem_wrq)
    else $error("mem_wrq longer than one cycle");

  a_req_spacing: assert property (@(posedge clk) disable iff (!rst_n)
    req |-> !pending)
    else $error("new memory request before mem_rdy of the previous one");

  // program write strobe only inside E9
  a_pgm_we_cmd: assert property (@(posedge clk) disable iff (!rst_n)
    dspx_pgm_we |-> (cmd_data == 8'hE9))
    else $error("dspx_pgm_we high outside command E9");

endmodule

bind mcu_cmd_top mcu_cmd_props props0 (
  .clk         (clk),
  .rst_n       (rst_n),
  .mem_rrq     (mem_rrq),
  .mem_wrq     (mem_wrq),
  .mem_rdy     (mem_rdy),
  .dspx_pgm_we (dspx_pgm_we),
  .cmd_data    (cmd_data)
);

//--- sim/tb_mcu_cmd.sv
`timescale 1ns/100ps
`include "mcu_cmd_defines.svh"

module tb_mcu_cmd
  import mcu_cmd_pkg::*;
();

  logic      clk;
  logic      rst_n;
  logic      cmd_ready;
  logic      param_ready;
  byte_t     cmd_data;
  byte_t     param_data;
  spi_cnt_t  spi_byte_cnt;
  byte_t     mem_rdata;
  logic      mem_rdy;
  byte_t     spi_data_out;
  mapper_t   mcu_mapper;
  mem_addr_t rom_mask;
  mem_addr_t saveram_mask;
  mem_addr_t mem_addr;
  byte_t     mem_wdata;
  logic      mem_rrq;
  logic      mem_wrq;
  pgm_word_t dspx_pgm_data;
  pgm_addr_t dspx_pgm_addr;
  logic      dspx_pgm_we;
  dat_word_t dspx_dat_data;
  dat_addr_t dspx_dat_addr;
  logic      dspx_dat_we;
  logic      dspx_reset;

  int          err_cnt;
  int          test_cnt;
  int          done_cnt;
  spi_cnt_t    next_idx;
  byte_t       mem_model [0:255];
  int unsigned dly_tab [0:15];
  mem_addr_t   wr_addr_q [$];

  mcu_cmd_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////
  // memory model answering the requests
  ////////////////////////////////////////
  initial begin : mem_responder
    logic      is_rd;
    mem_addr_t a;
    int        dly_idx;
    mem_rdy   = 1'b0;
    mem_rdata = '0;
    done_cnt  = 0;
    dly_idx   = 0;
    forever begin
      @(posedge clk);
      if (mem_rrq || mem_wrq) begin
        is_rd = mem_rrq;
        a     = mem_addr;
        if (!is_rd) begin
          mem_model[a[7:0]] = mem_wdata;
          wr_addr_q.push_back(a);
        end
        repeat (dly_tab[dly_idx]) @(negedge clk);
        dly_idx = (dly_idx + 1) % 16;
        if (is_rd) begin
          mem_rdata = mem_model[a[7:0]];
        end
        @(negedge clk);
        mem_rdy = 1'b1;
        repeat (3) @(negedge clk);
        mem_rdy = 1'b0;
        done_cnt++;
      end
    end
  end

  task automatic send_cmd(input byte_t b);
    @(negedge clk);
    cmd_ready    = 1'b1;
    cmd_data     = b;
    spi_byte_cnt = spi_cnt_t'(1);
    @(negedge clk);
    cmd_ready = 1'b0;
    next_idx  = spi_cnt_t'(2);
  endtask

  task automatic send_param(input byte_t b);
    @(negedge clk);
    param_ready  = 1'b1;
    param_data   = b;
    spi_byte_cnt = next_idx;
    @(negedge clk);
    param_ready = 1'b0;
    next_idx    = next_idx + 1'b1;
  endtask

  // command followed by a 24-bit value, msb first
  task automatic send_cmd_addr(input byte_t c, input mem_addr_t v);
    send_cmd(c);
    send_param(v[23:16]);
    send_param(v[15:8]);
    send_param(v[7:0]);
  endtask

  task automatic wait_mem_done();
    int target;
    int n;
    target = done_cnt + 1;
    n      = 0;
    while (done_cnt < target && n < 50) begin
      @(posedge clk);
      n++;
    end
    if (done_cnt < target) begin
      $display("memory access not completed within 50 cycles at %0t", $time);
      $display("Test failed");
      $finish;
    end else begin
      @(negedge clk);
    end
  endtask

  task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("[FAIL] %0t %s expected %0h actual %0h", $time, sig, exp, act);
    err_cnt++;
  endtask

  task automatic finish_test(input string name, input int err_before);
    test_cnt++;
    if (err_cnt == err_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, err_cnt - err_before);
    end
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////
  task automatic check_reset_values();
    int e0;
    e0 = err_cnt;
    if (mem_rrq !== 1'b0) report_mismatch("mem_rrq", 0, mem_rrq);
    if (mem_wrq !== 1'b0) report_mismatch("mem_wrq", 0, mem_wrq);
    if (dspx_pgm_we !== 1'b0) report_mismatch("dspx_pgm_we", 0, dspx_pgm_we);
    if (dspx_dat_we !== 1'b0) report_mismatch("dspx_dat_we", 0, dspx_dat_we);
    if (dspx_reset !== 1'b1) report_mismatch("dspx_reset", 1, dspx_reset);
    if (mcu_mapper !== `MAPPER_RST) report_mismatch("mcu_mapper", `MAPPER_RST, mcu_mapper);
    if (rom_mask !== '0) report_mismatch("rom_mask", 0, rom_mask);
    if (saveram_mask !== '0) report_mismatch("saveram_mask", 0, saveram_mask);
    if (mem_addr !== '0) report_mismatch("mem_addr", 0, mem_addr);
    if (dspx_pgm_addr !== '0) report_mismatch("dspx_pgm_addr", 0, dspx_pgm_addr);
    if (dspx_dat_addr !== '0) report_mismatch("dspx_dat_addr", 0, dspx_dat_addr);
    if (spi_data_out !== '0) report_mismatch("spi_data_out", 0, spi_data_out);
    finish_test("reset values", e0);
  endtask

  task automatic config_regs();
    mem_addr_t m;
    int        e0;
    e0 = err_cnt;
    send_cmd(8'h35);
    if (mcu_mapper !== 3'd5) report_mismatch("mcu_mapper", 5, mcu_mapper);
    m = mem_addr_t'($urandom);
    send_cmd_addr(8'h10, m);
    if (rom_mask !== m) report_mismatch("rom_mask", m, rom_mask);
    m = mem_addr_t'($urandom);
    send_cmd_addr(8'h20, m);
    if (saveram_mask !== m) report_mismatch("saveram_mask", m, saveram_mask);
    finish_test("configuration", e0);
  endtask

  task automatic readback_echo();
    byte_t p;
    int    e0;
    e0 = err_cnt;
    send_cmd(8'hF0);
    if (spi_data_out !== `READBACK_SIG)
      report_mismatch("spi_data_out", `READBACK_SIG, spi_data_out);
    p = byte_t'($urandom);
    send_cmd(8'hFF);
    send_param(p);
    if (spi_data_out !== p) report_mismatch("spi_data_out", p, spi_data_out);
    finish_test("readback", e0);
  endtask

  task automatic write_burst();
    mem_addr_t start;
    mem_addr_t a;
    byte_t     wd [0:3];
    int        i;
    int        e0;
    e0    = err_cnt;
    start = 24'h1234FE;
    send_cmd_addr(8'h00, start);
    if (mem_addr !== start) report_mismatch("mem_addr", start, mem_addr);
    wr_addr_q.delete();
    send_cmd(8'h98);
    for (i = 0; i < 4; i++) begin
      wd[i] = byte_t'($urandom);
      send_param(wd[i]);
      wait_mem_done();
    end
    if (wr_addr_q.size() != 4) begin
      $display("memory saw %0d writes instead of 4", wr_addr_q.size());
      err_cnt++;
    end else begin
      for (i = 0; i < 4; i++) begin
        a = start + i;
        if (wr_addr_q[i] !== a) report_mismatch("write address", a, wr_addr_q[i]);
        if (mem_model[a[7:0]] !== wd[i])
          report_mismatch("stored byte", wd[i], mem_model[a[7:0]]);
      end
    end
    if (mem_addr !== start + 4) report_mismatch("mem_addr", start + 4, mem_addr);
    finish_test("memory write", e0);
  endtask

  task automatic read_burst();
    mem_addr_t start;
    mem_addr_t a;
    int        i;
    int        e0;
    e0    = err_cnt;
    start = 24'h005680;
    send_cmd_addr(8'h00, start);
    // the command byte itself starts the first read
    send_cmd(8'h88);
    for (i = 0; i < 4; i++) begin
      if (i > 0) send_param(byte_t'($urandom));
      wait_mem_done();
      a = start + i;
      if (spi_data_out !== mem_model[a[7:0]])
        report_mismatch("spi_data_out", mem_model[a[7:0]], spi_data_out);
      if (mem_addr !== a + 1) report_mismatch("mem_addr", a + 1, mem_addr);
    end
    // bit 3 clear, pointer stays put
    a = start + 4;
    send_cmd(8'h80);
    for (i = 0; i < 2; i++) begin
      if (i > 0) begin
        // new content at the same address
        mem_model[a[7:0]] = ~mem_model[a[7:0]];
        send_param(byte_t'($urandom));
      end
      wait_mem_done();
      if (spi_data_out !== mem_model[a[7:0]])
        report_mismatch("spi_data_out", mem_model[a[7:0]], spi_data_out);
      if (mem_addr !== a) report_mismatch("mem_addr", a, mem_addr);
    end
    finish_test("memory read", e0);
  endtask

  task automatic dsp_loading();
    pgm_word_t w;
    dat_word_t dw;
    int        i;
    int        e0;
    e0 = err_cnt;
    send_cmd(8'hE8);
    send_param(8'h00);
    if (dspx_pgm_addr !== '0) report_mismatch("dspx_pgm_addr", 0, dspx_pgm_addr);
    for (i = 0; i < 2; i++) begin
      w = pgm_word_t'($urandom);
      send_cmd_addr(8'hE9, w);
      send_param(8'h00);
      if (dspx_pgm_we !== 1'b1) report_mismatch("dspx_pgm_we", 1, dspx_pgm_we);
      if (dspx_pgm_data !== w) report_mismatch("dspx_pgm_data", w, dspx_pgm_data);
      send_param(8'h00);
      if (dspx_pgm_we !== 1'b0) report_mismatch("dspx_pgm_we", 0, dspx_pgm_we);
    end
    if (dspx_pgm_addr !== 11'd2) report_mismatch("dspx_pgm_addr", 2, dspx_pgm_addr);
    dw = dat_word_t'($urandom);
    send_cmd(8'hEA);
    send_param(dw[15:8]);
    send_param(dw[7:0]);
    send_param(8'h00);
    if (dspx_dat_we !== 1'b1) report_mismatch("dspx_dat_we", 1, dspx_dat_we);
    if (dspx_dat_data !== dw) report_mismatch("dspx_dat_data", dw, dspx_dat_data);
    send_param(8'h00);
    if (dspx_dat_we !== 1'b0) report_mismatch("dspx_dat_we", 0, dspx_dat_we);
    if (dspx_dat_addr !== 10'd1) report_mismatch("dspx_dat_addr", 1, dspx_dat_addr);
    send_cmd(8'hEB);
    send_param(8'h00);
    if (dspx_reset !== 1'b0) report_mismatch("dspx_reset", 0, dspx_reset);
    send_cmd(8'hE8);
    send_param(8'h00);
    if (dspx_pgm_addr !== '0) report_mismatch("dspx_pgm_addr", 0, dspx_pgm_addr);
    if (dspx_dat_addr !== '0) report_mismatch("dspx_dat_addr", 0, dspx_dat_addr);
    finish_test("dsp loading", e0);
  endtask

  initial begin : main_seq
    int unsigned seed_val;
    int          i;
    seed_val = $urandom(32'hd0b1);
    err_cnt  = 0;
    test_cnt = 0;
    for (i = 0; i < 256; i++) begin
      mem_model[i] = byte_t'($urandom);
    end
    // 2 to 5 cycles of memory latency
    for (i = 0; i < 16; i++) begin
      dly_tab[i] = 2 + ($urandom % 4);
    end
    rst_n        = 1'b0;
    cmd_ready    = 1'b0;
    param_ready  = 1'b0;
    cmd_data     = '0;
    param_data   = '0;
    spi_byte_cnt = '0;
    next_idx     = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_reset_values();
    config_regs();
    readback_echo();
    write_burst();
    read_burst();
    dsp_loading();
    $display("tests run %0d, errors %0d", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+logic
logic/mcu_cmd_pkg.sv
logic/mcu_cmd_if.sv
logic/mcu_cfg_decode.sv
logic/mcu_mem_port.sv
logic/dspx_loader.sv
logic/mcu_readback.sv
logic/mcu_cmd_top.sv
sim/mcu_cmd_props.sv
sim/tb_mcu_cmd.sv

//--- Bender.yml
package:
  name: mcu_cmd

sources:
  - include_dirs:
      - logic
    files:
      - logic/mcu_cmd_pkg.sv
      - logic/mcu_cmd_if.sv
      - logic/mcu_cfg_decode.sv
      - logic/mcu_mem_port.sv
      - logic/dspx_loader.sv
      - logic/mcu_readback.sv
      - logic/mcu_cmd_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/mcu_cmd_props.sv
      - sim/tb_mcu_cmd.sv
